/* design/lock_pkg.sv */
package lock_pkg;

    typedef enum logic [3:0] {
        KEY_0      = 4'd0,
        KEY_1      = 4'd1,
        KEY_2      = 4'd2,
        KEY_3      = 4'd3,
        KEY_4      = 4'd4,
        KEY_5      = 4'd5,
        KEY_6      = 4'd6,
        KEY_7      = 4'd7,
        KEY_8      = 4'd8,
        KEY_9      = 4'd9,
        KEY_ENTER  = 4'd10,
        KEY_CLEAR  = 4'd11,
        KEY_CANCEL = 4'd12,
        KEY_PANIC  = 4'd13
    } key_e;

    // one-hot matrix words, bits 1 and 2 are not wired to keys
    localparam logic [15:0] KEY_WORD_0      = 16'h0008;
    localparam logic [15:0] KEY_WORD_1      = 16'h0080;
    localparam logic [15:0] KEY_WORD_2      = 16'h0040;
    localparam logic [15:0] KEY_WORD_3      = 16'h0020;
    localparam logic [15:0] KEY_WORD_4      = 16'h0800;
    localparam logic [15:0] KEY_WORD_5      = 16'h0400;
    localparam logic [15:0] KEY_WORD_6      = 16'h0200;
    localparam logic [15:0] KEY_WORD_7      = 16'h8000;
    localparam logic [15:0] KEY_WORD_8      = 16'h0010;
    localparam logic [15:0] KEY_WORD_9      = 16'h2000;
    localparam logic [15:0] KEY_WORD_ENTER  = 16'h0001;
    localparam logic [15:0] KEY_WORD_CLEAR  = 16'h0100;
    localparam logic [15:0] KEY_WORD_CANCEL = 16'h1000;
    localparam logic [15:0] KEY_WORD_PANIC  = 16'h4000;

    localparam logic [1:0]  CODE_DIGITS = 2'd3;
    localparam logic [11:0] SECRET_CODE = 12'h246;  // 2-4-6, first digit on top
    localparam logic [1:0]  MAX_TRIES   = 2'd3;

    localparam logic [3:0] GLYPH_BLANK = 4'hF;
    localparam logic [3:0] GLYPH_A     = 4'hB;
    localparam logic [3:0] GLYPH_S     = 4'hC;

    localparam int LOCKOUT_SECS  = 20;
    localparam int SECOND_CYCLES = 50;  // slow system clock
    localparam int SECOND_CNT_W  = $clog2(SECOND_CYCLES);
    localparam logic [SECOND_CNT_W-1:0] SECOND_LAST = SECOND_CNT_W'(SECOND_CYCLES - 1);
    localparam logic [7:0] LOCKOUT_BCD = {4'(LOCKOUT_SECS / 10), 4'(LOCKOUT_SECS % 10)};

    // buzzer patterns, lengths and half periods in clocks
    localparam logic [6:0] CLICK_LEN    = 7'd20;
    localparam logic [2:0] CLICK_HALF   = 3'd2;
    localparam logic [6:0] SUCCESS_LEN  = 7'd60;
    localparam logic [2:0] SUCCESS_HALF = 3'd1;
    localparam logic [6:0] FAIL_LEN     = 7'd90;
    localparam logic [2:0] FAIL_HALF    = 3'd4;
    localparam logic [6:0] FAIL_GAP_LO  = 7'd30;
    localparam logic [6:0] FAIL_GAP_HI  = 7'd60;

endpackage

/* design/key_decoder.sv */
`timescale 1ns/1ns

module key_decoder (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [15:0]        onehot,
    output logic               key_valid,
    output lock_pkg::key_e     key_code
);

    logic [15:0]    word_q;     // sampled key word
    logic [15:0]    word_prev;  // word one cycle earlier
    logic           key_hit;
    lock_pkg::key_e key_dec;

    always_comb begin
        key_hit = 1'b1;
        key_dec = lock_pkg::KEY_0;
        case (word_q)
            lock_pkg::KEY_WORD_0:      key_dec = lock_pkg::KEY_0;
            lock_pkg::KEY_WORD_1:      key_dec = lock_pkg::KEY_1;
            lock_pkg::KEY_WORD_2:      key_dec = lock_pkg::KEY_2;
            lock_pkg::KEY_WORD_3:      key_dec = lock_pkg::KEY_3;
            lock_pkg::KEY_WORD_4:      key_dec = lock_pkg::KEY_4;
            lock_pkg::KEY_WORD_5:      key_dec = lock_pkg::KEY_5;
            lock_pkg::KEY_WORD_6:      key_dec = lock_pkg::KEY_6;
            lock_pkg::KEY_WORD_7:      key_dec = lock_pkg::KEY_7;
            lock_pkg::KEY_WORD_8:      key_dec = lock_pkg::KEY_8;
            lock_pkg::KEY_WORD_9:      key_dec = lock_pkg::KEY_9;
            lock_pkg::KEY_WORD_ENTER:  key_dec = lock_pkg::KEY_ENTER;
            lock_pkg::KEY_WORD_CLEAR:  key_dec = lock_pkg::KEY_CLEAR;
            lock_pkg::KEY_WORD_CANCEL: key_dec = lock_pkg::KEY_CANCEL;
            lock_pkg::KEY_WORD_PANIC:  key_dec = lock_pkg::KEY_PANIC;
            default:                   key_hit = 1'b0;  // zero, unused or multi-bit
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_q    <= '0;
            word_prev <= '0;
            key_valid <= 1'b0;
        end else begin
            word_q    <= onehot;
            word_prev <= word_q;
            key_valid <= key_hit && (word_q != word_prev);  // edge on a new key only
        end
    end

    always_ff @(posedge clk) begin
        key_code <= key_dec;
    end

    // a key has to be held for more than one clock
    a_single_event: assert property (
        @(posedge clk) disable iff (!arst_n)
        key_valid |=> !key_valid
    );

endmodule

/* design/code_entry.sv */
`timescale 1ns/1ns

module code_entry (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        digit_push,
    input  logic [3:0]  digit,
    input  logic        entry_clear,
    output logic [11:0] entry_digits,
    output logic [1:0]  entry_count
);

    logic [11:0] entry_q;
    logic [1:0]  count_q;
    logic        entry_full;

    assign entry_full = (count_q == lock_pkg::CODE_DIGITS);

    // blank glyphs fill the entry, so unused positions read blank after a shift
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_q <= {3{lock_pkg::GLYPH_BLANK}};
            count_q <= 2'd0;
        end else if (entry_clear) begin
            entry_q <= {3{lock_pkg::GLYPH_BLANK}};
            count_q <= 2'd0;
        end else if (digit_push && !entry_full) begin
            entry_q <= {entry_q[7:0], digit};  // newest digit on the right
            count_q <= count_q + 2'd1;
        end
    end

    assign entry_digits = entry_q;
    assign entry_count  = count_q;

    // a full entry never wraps back to empty
    a_count_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        entry_full && !entry_clear |=> entry_full
    );

    // the controller only forwards decimal keys
    a_digit_decimal: assert property (
        @(posedge clk) disable iff (!arst_n)
        digit_push |-> (digit <= 4'd9)
    );

endmodule

/* design/lock_ctrl.sv */
`timescale 1ns/1ns

module lock_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                key_valid,
    input  lock_pkg::key_e      key_code,
    input  logic [11:0]         entry_digits,
    input  logic [1:0]          entry_count,
    output logic                digit_push,
    output logic [3:0]          digit,
    output logic                entry_clear,
    output logic                req_click,
    output logic                req_success,
    output logic                req_fail,
    output logic [11:0]         display,
    output logic                unlocked,
    output logic [1:0]          tries,
    output logic                locked_out
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_OPEN,
        ST_LOCKOUT
    } state_e;

    state_e                              state_q;
    logic [1:0]                          tries_q;
    logic [7:0]                          secs_q;   // two BCD digits
    logic [lock_pkg::SECOND_CNT_W-1:0]   presc_q;
    logic                                is_digit;
    logic                                code_match;
    logic                                entry_full;

    assign is_digit   = (key_code <= lock_pkg::KEY_9);
    assign code_match = (entry_digits == lock_pkg::SECRET_CODE);
    assign entry_full = (entry_count == lock_pkg::CODE_DIGITS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= ST_IDLE;
            tries_q     <= 2'd0;
            secs_q      <= 8'h00;
            presc_q     <= '0;
            digit_push  <= 1'b0;
            entry_clear <= 1'b0;
            req_click   <= 1'b0;
            req_success <= 1'b0;
            req_fail    <= 1'b0;
        end else begin
            digit_push  <= 1'b0;  // all requests are single pulses
            entry_clear <= 1'b0;
            req_click   <= 1'b0;
            req_success <= 1'b0;
            req_fail    <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (key_valid && is_digit) begin
                        digit_push <= 1'b1;  // entry drops it when full
                        req_click  <= 1'b1;
                    end else if (key_valid) begin
                        case (key_code)
                            lock_pkg::KEY_CANCEL: begin
                                entry_clear <= 1'b1;
                                req_click   <= 1'b1;
                            end
                            lock_pkg::KEY_CLEAR: begin
                                entry_clear <= 1'b1;
                                tries_q     <= 2'd0;
                                req_click   <= 1'b1;
                            end
                            lock_pkg::KEY_ENTER: begin
                                if (entry_full && code_match) begin
                                    state_q     <= ST_OPEN;
                                    entry_clear <= 1'b1;
                                    req_success <= 1'b1;
                                end else if (entry_full) begin
                                    entry_clear <= 1'b1;
                                    req_fail    <= 1'b1;
                                    tries_q     <= tries_q + 2'd1;
                                    if (tries_q == lock_pkg::MAX_TRIES - 2'd1) begin
                                        state_q <= ST_LOCKOUT;  // last try used up
                                        secs_q  <= lock_pkg::LOCKOUT_BCD;
                                        presc_q <= '0;
                                    end
                                end
                            end
                            lock_pkg::KEY_PANIC: begin
                                state_q     <= ST_LOCKOUT;
                                secs_q      <= lock_pkg::LOCKOUT_BCD;
                                presc_q     <= '0;
                                entry_clear <= 1'b1;
                                req_fail    <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                ST_OPEN: begin
                    if (key_valid && key_code == lock_pkg::KEY_CLEAR) begin
                        state_q   <= ST_IDLE;  // relock
                        tries_q   <= 2'd0;
                        req_click <= 1'b1;
                    end else if (key_valid && key_code == lock_pkg::KEY_PANIC) begin
                        state_q  <= ST_LOCKOUT;
                        secs_q   <= lock_pkg::LOCKOUT_BCD;
                        presc_q  <= '0;
                        req_fail <= 1'b1;
                    end
                end
                ST_LOCKOUT: begin
                    // keys are dropped here, only the countdown runs
                    if (presc_q == lock_pkg::SECOND_LAST) begin
                        presc_q <= '0;
                        if (secs_q == 8'h00) begin
                            state_q <= ST_IDLE;
                            tries_q <= 2'd0;
                        end else if (secs_q[3:0] == 4'd0) begin
                            secs_q <= {secs_q[7:4] - 4'd1, 4'd9};  // borrow from tens
                        end else begin
                            secs_q[3:0] <= secs_q[3:0] - 4'd1;
                        end
                    end else begin
                        presc_q <= presc_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid && is_digit) begin
            digit <= key_code;
        end
    end

    always_comb begin
        case (state_q)
            ST_OPEN:    display = {lock_pkg::GLYPH_A, lock_pkg::GLYPH_S, lock_pkg::GLYPH_S};
            ST_LOCKOUT: display = {4'h0, secs_q};
            default:    display = entry_digits;
        endcase
    end

    assign unlocked   = (state_q == ST_OPEN);
    assign locked_out = (state_q == ST_LOCKOUT);
    assign tries      = tries_q;

    // no key reaches the entry or the buzzer during lockout
    a_lockout_quiet: assert property (
        @(posedge clk) disable iff (!arst_n)
        locked_out |=> !(digit_push || entry_clear || req_click || req_success || req_fail)
    );

    a_bcd_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        (secs_q[7:4] <= 4'd9) && (secs_q[3:0] <= 4'd9)
    );

endmodule

/* design/tone_gen.sv */
`timescale 1ns/1ns

module tone_gen (
    input  logic clk,
    input  logic arst_n,
    input  logic req_click,
    input  logic req_success,
    input  logic req_fail,
    output logic buzzer
);

    typedef enum logic [1:0] {
        TONE_NONE,
        TONE_CLICK,
        TONE_SUCCESS,
        TONE_FAIL
    } tone_e;

    tone_e      pat_q;
    logic [6:0] len_q;     // clocks since pattern start
    logic [2:0] half_q;    // clocks since last toggle
    logic [6:0] cur_len;
    logic [2:0] cur_half;
    logic       any_req;
    logic       in_gap;

    assign any_req = req_click || req_success || req_fail;
    assign in_gap  = (pat_q == TONE_FAIL) && (len_q >= lock_pkg::FAIL_GAP_LO)
                     && (len_q < lock_pkg::FAIL_GAP_HI);

    always_comb begin
        case (pat_q)
            TONE_SUCCESS: begin
                cur_len  = lock_pkg::SUCCESS_LEN;
                cur_half = lock_pkg::SUCCESS_HALF;
            end
            TONE_FAIL: begin
                cur_len  = lock_pkg::FAIL_LEN;
                cur_half = lock_pkg::FAIL_HALF;
            end
            default: begin
                cur_len  = lock_pkg::CLICK_LEN;
                cur_half = lock_pkg::CLICK_HALF;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pat_q  <= TONE_NONE;
            len_q  <= 7'd0;
            half_q <= 3'd0;
            buzzer <= 1'b0;
        end else if (any_req) begin
            // fail wins over success, success over click
            if (req_fail) begin
                pat_q <= TONE_FAIL;
            end else if (req_success) begin
                pat_q <= TONE_SUCCESS;
            end else begin
                pat_q <= TONE_CLICK;
            end
            len_q  <= 7'd0;
            half_q <= 3'd0;
            buzzer <= 1'b1;  // restart high
        end else if (pat_q != TONE_NONE) begin
            len_q <= len_q + 7'd1;
            if (len_q == cur_len - 7'd1) begin
                pat_q  <= TONE_NONE;  // pattern done
                half_q <= 3'd0;
                buzzer <= 1'b0;
            end else if (half_q == cur_half - 3'd1) begin
                half_q <= 3'd0;
                buzzer <= in_gap ? 1'b0 : ~buzzer;
            end else begin
                half_q <= half_q + 3'd1;
                if (in_gap) begin
                    buzzer <= 1'b0;  // broken fail tone
                end
            end
        end else begin
            buzzer <= 1'b0;
        end
    end

    a_one_request: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({req_click, req_success, req_fail})
    );

endmodule

/* design/code_lock.sv */
`timescale 1ns/1ns

module code_lock (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [15:0] onehot,
    output logic [11:0] display,
    output logic        unlocked,
    output logic [1:0]  tries,
    output logic        locked_out,
    output logic        buzzer
);

    logic           key_valid;
    lock_pkg::key_e key_code;
    logic           digit_push;
    logic [3:0]     digit;
    logic           entry_clear;
    logic [11:0]    entry_digits;
    logic [1:0]     entry_count;
    logic           req_click;
    logic           req_success;
    logic           req_fail;

    key_decoder key_decoder_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .onehot    (onehot),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    code_entry code_entry_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .digit_push   (digit_push),
        .digit        (digit),
        .entry_clear  (entry_clear),
        .entry_digits (entry_digits),
        .entry_count  (entry_count)
    );

    lock_ctrl lock_ctrl_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .entry_digits (entry_digits),
        .entry_count  (entry_count),
        .digit_push   (digit_push),
        .digit        (digit),
        .entry_clear  (entry_clear),
        .req_click    (req_click),
        .req_success  (req_success),
        .req_fail     (req_fail),
        .display      (display),
        .unlocked     (unlocked),
        .tries        (tries),
        .locked_out   (locked_out)
    );

    tone_gen tone_gen_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_click   (req_click),
        .req_success (req_success),
        .req_fail    (req_fail),
        .buzzer      (buzzer)
    );

endmodule

/* tb/code_lock_tb.sv */
`timescale 1ns/1ns

module code_lock_tb;

    localparam int LOCK_CYCLES = (lock_pkg::LOCKOUT_SECS + 1) * lock_pkg::SECOND_CYCLES;

    logic        clk;
    logic        arst_n;
    logic [15:0] onehot;
    logic [11:0] display;
    logic        unlocked;
    logic [1:0]  tries;
    logic        locked_out;
    logic        buzzer;

    logic [47:0] cases [0:63];  // kind, key, buzz, display, unlocked, tries, locked_out
    int          n_cases;
    int          n_checks;
    int          n_errors;
    int          wd_cycles;

    code_lock code_lock_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .onehot     (onehot),
        .display    (display),
        .unlocked   (unlocked),
        .tries      (tries),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [11:0] got,
                               input logic [11:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_state(input logic [47:0] c);
        if (c[47:44] == 4'h3) begin
            check_field("countdown top digit", display[11:8], 12'h0);  // seconds keep moving
        end else begin
            check_field("display", display, c[23:12]);
        end
        check_field("unlocked", unlocked, c[11:8]);
        check_field("tries", tries, c[7:4]);
        check_field("locked_out", locked_out, c[3:0]);
    endtask

    task automatic press_key(input logic [15:0] word, input logic buzz_on, input logic silent);
        int   hold;
        int   gap;
        int   junk_at;
        int   i;
        logic heard;
        hold    = $urandom_range(6, 2);
        gap     = $urandom_range(6, 3);
        junk_at = ($urandom_range(2, 0) == 0) ? hold + 1 : -1;
        heard   = 1'b0;
        for (i = 0; i < hold + gap; i++) begin
            @(negedge clk);
            heard = heard | buzzer;
            if (i == 4 && buzz_on) begin
                check_field("buzzer", buzzer, 12'd1);  // tone starts one edge after request
            end
            if (i < hold) begin
                onehot = word;
            end else if (i == junk_at) begin
                onehot = $urandom_range(1, 0) ? 16'h0004 : (word | 16'h0002);  // no key
            end else begin
                onehot = '0;
            end
        end
        if (silent) begin
            check_field("buzzer in lockout", heard, 12'd0);
        end
        @(negedge clk);
    endtask

    // seconds counted down by one in decimal
    function automatic logic [7:0] bcd_down(input logic [7:0] secs);
        int value;
        value = secs[7:4] * 10 + secs[3:0] - 1;
        return {4'(value / 10), 4'(value % 10)};
    endfunction

    task automatic wait_lockout_end();
        int         waited;
        int         since;
        int         steps;
        logic [7:0] secs_seen;
        waited    = 0;
        since     = 0;
        steps     = 0;
        secs_seen = display[7:0];
        while (locked_out && waited < LOCK_CYCLES) begin
            @(negedge clk);
            waited++;
            since++;
            if (!locked_out) begin
                check_field("final countdown value", secs_seen, 12'h00);
                if (steps > 0) begin
                    check_field("last second length", 12'(since), 12'(lock_pkg::SECOND_CYCLES));
                end
            end else if (display[7:0] != secs_seen) begin
                check_field("countdown step", display[7:0], bcd_down(secs_seen));
                if (steps > 0) begin
                    check_field("second length", 12'(since), 12'(lock_pkg::SECOND_CYCLES));
                end
                secs_seen = display[7:0];
                since     = 0;
                steps++;
            end
        end
        n_checks++;
        assert (!locked_out) else begin
            $display("lockout was still active after %0d cycles", LOCK_CYCLES);
            n_errors++;
        end
        repeat (2) @(negedge clk);
    endtask

    initial begin
        logic [47:0] c;
        int          err_before;
        int          idx;
        onehot    = '0;
        arst_n    = 1'b0;
        n_cases   = 0;
        n_checks  = 0;
        n_errors  = 0;
        wd_cycles = 0;
        void'($urandom(25));
        for (idx = 0; idx < 64; idx++) begin
            cases[idx] = '0;
        end
        $readmemh("tb/code_lock_cases.txt", cases);
        while (n_cases < 64 && cases[n_cases][47:44] != 4'h0) begin
            n_cases++;  // kind 0 ends the list
        end
        wd_cycles = n_cases * 20 + 2 * LOCK_CYCLES;
        n_checks++;
        assert (n_cases > 0) else begin
            $display("no cases were read from tb/code_lock_cases.txt");
            n_errors++;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_state(48'h1_0000_0_FFF_0_0_0);  // idle after reset
        for (idx = 0; idx < n_cases; idx++) begin
            c          = cases[idx];
            err_before = n_errors;
            case (c[47:44])
                4'h2: wait_lockout_end();
                4'h3: begin
                    repeat (lock_pkg::FAIL_LEN) @(negedge clk);  // fail tone dies out
                    press_key(c[43:28], 1'b0, 1'b1);
                end
                default: press_key(c[43:28], c[24], 1'b0);
            endcase
            check_state(c);
            $display("case %0d kind %0h key %h: %s", idx, c[47:44], c[43:28],
                     (n_errors == err_before) ? "ok" : "mismatch");
        end
        $display("cases %0d, checks %0d, errors %0d", n_cases, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("run timed out after %0d cycles", wd_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

/* tb/code_lock_cases.txt */
// kind: 1 press, 2 wait for lockout end, 3 press while locked out (must stay silent)
// columns in hex: kind_key_buzz_display_unlocked_tries_lockedout
1_0080_1_FF1_0_0_0  // digit 1
1_0040_1_F12_0_0_0
1_0020_1_123_0_0_0
1_0800_1_123_0_0_0  // fourth digit dropped
1_1000_1_FFF_0_0_0  // cancel
1_0040_1_FF2_0_0_0
1_0001_0_FF2_0_0_0  // short entry, enter ignored
1_0800_1_F24_0_0_0
1_0200_1_246_0_0_0
1_0001_1_BCC_1_0_0  // open
1_0400_0_BCC_1_0_0  // digit ignored while open
1_0100_1_FFF_0_0_0  // clear relocks
1_2000_1_FF9_0_0_0
1_0010_1_F98_0_0_0
1_8000_1_987_0_0_0
1_0001_1_FFF_0_1_0  // wrong code
1_0100_1_FFF_0_0_0  // clear drops tries
1_0008_1_FF0_0_0_0
1_0008_1_F00_0_0_0
1_0008_1_000_0_0_0
1_0001_1_FFF_0_1_0
1_0008_1_FF0_0_1_0
1_0008_1_F00_0_1_0
1_0008_1_000_0_1_0
1_0001_1_FFF_0_2_0
1_0008_1_FF0_0_2_0
1_0008_1_F00_0_2_0
1_0008_1_000_0_2_0
1_0001_1_020_0_3_1  // third failure, lockout
3_0400_0_000_0_3_1
3_0001_0_000_0_3_1
2_0000_0_FFF_0_0_0  // countdown over
1_4000_1_020_0_0_1  // panic
3_0040_0_000_0_0_1
2_0000_0_FFF_0_0_0

/* code_lock.f */
design/lock_pkg.sv
design/key_decoder.sv
design/code_entry.sv
design/lock_ctrl.sv
design/tone_gen.sv
design/code_lock.sv
tb/code_lock_tb.sv

/* Bender.yml */
package:
  name: code_lock

sources:
  - design/lock_pkg.sv
  - design/key_decoder.sv
  - design/code_entry.sv
  - design/lock_ctrl.sv
  - design/tone_gen.sv
  - design/code_lock.sv
  - target: test
    files:
      - tb/code_lock_tb.sv
